/* project.f */
hdl/vec_pkg.sv
hdl/instr_fifo.sv
hdl/vec_scheduler.sv
hdl/mem_agu.sv
hdl/vec_cu.sv
hdl/vector_issue_top.sv
dv/vector_issue_assert.sv
dv/vector_issue_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vector_issue_tb \
   -f project.f -o vector_issue_sim || exit 1
./obj_dir/vector_issue_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

/* dv/vector_issue_tb.sv */
// testbench of the vector issue stage
// seeded random stimulus, reference model of retire records and addresses, report
module vector_issue_tb;
   import vec_pkg::*;

   localparam int FIFO_DEPTH   = 4;
   localparam int NUM_ELEM     = 8;
   localparam int RETIRE_DEPTH = 4;
   localparam int TOTAL_INSTR  = 96;
   localparam int CYCLE_LIMIT  = TOTAL_INSTR * (NUM_ELEM + 4) * 4 + 200;
   // wide enough for a whole retire record
   localparam int CMP_W        = $bits(dispatch_t);

   logic        clk = 1'b0;
   logic        rstn;
   logic [1:0]  sew_i;
   logic        in_valid_i;
   logic        in_ready_o;
   scalar_req_t in_data_i;
   logic        mem_req_valid_o;
   logic        mem_req_ready_i;
   mem_req_t    mem_req_o;
   logic        retire_valid_o;
   logic        retire_ready_i;
   dispatch_t   retire_o;

   scalar_req_t reqs [$];
   dispatch_t   exp_ret [$];
   mem_req_t    exp_addr [$];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   vector_issue_top #(
      .FIFO_DEPTH(FIFO_DEPTH), .NUM_ELEM(NUM_ELEM), .RETIRE_DEPTH(RETIRE_DEPTH)
   ) vector_issue_top_inst (
      .clk(clk), .rstn(rstn), .sew_i(sew_i),
      .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_data_i(in_data_i),
      .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
      .mem_req_o(mem_req_o),
      .retire_valid_o(retire_valid_o), .retire_ready_i(retire_ready_i),
      .retire_o(retire_o)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout, run still busy after %0d cycles", cycles);
         $display("test failed");
         $finish;
      end
   end

   task automatic compare(input string name, input logic [CMP_W-1:0] exp,
                          input logic [CMP_W-1:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   function automatic logic [31:0] elem_size(input logic [2:0] width);
      case (width)
         3'd5:    return 32'd2;
         3'd6:    return 32'd4;
         3'd7:    return 32'd8;
         default: return 32'd1;
      endcase
   endfunction

   // width code of an 8, 16, 32 or 64 bit element
   function automatic logic [2:0] sew_code(input logic [1:0] sew);
      case (sew)
         2'd0:    return 3'd0;
         2'd1:    return 3'd5;
         2'd2:    return 3'd6;
         default: return 3'd7;
      endcase
   endfunction

   function automatic logic [2:0] pick_width();
      case ($urandom_range(0, 3))
         0:       return 3'd0;
         1:       return 3'd5;
         2:       return 3'd6;
         default: return 3'd7;
      endcase
   endfunction

   task automatic expect_addrs(input logic [31:0] base, input logic [31:0] step, input logic st);
      mem_req_t a;
      for (int k = 0; k < NUM_ELEM; k++)
      begin
         a.addr     = base + 32'(k) * step;
         a.is_store = st;
         exp_addr.push_back(a);
      end
   endtask

   task automatic add_arith(input logic force_cfg);
      vec_instr_u  w;
      scalar_req_t r;
      dispatch_t   d;
      w = $urandom;
      w.arith.opcode = v_arith_opcode;
      if (force_cfg)
         w.arith.funct3 = OPCFG;
      case (w.arith.funct3)
         OPIVV, OPIVI, OPIVX: d.cls = CLS_INT;
         OPMVV, OPMVX:        d.cls = (w.arith.funct6[5:3] == 3'b101) ? CLS_MASK101 : CLS_MASK;
         OPCFG:               d.cls = CLS_CFG;
         default:             d.cls = CLS_ILLEGAL;
      endcase
      r.instr = w;
      r.rs1   = $urandom;
      r.rs2   = $urandom;
      d.instr = w;
      d.rs1   = r.rs1;
      d.rs2   = r.rs2;
      reqs.push_back(r);
      exp_ret.push_back(d);
   endtask

   task automatic add_mem(input logic [6:0] opc, input mop_e mop, input logic [1:0] sew);
      vec_instr_u  w;
      scalar_req_t r;
      dispatch_t   d;
      logic        st;
      logic        idx;
      st  = (opc == v_st_opcode);
      idx = (mop == idx_unordered || mop == idx_ordered);
      w = $urandom;
      w.mem.opcode = opc;
      w.mem.mop    = mop;
      w.mem.width  = pick_width();
      r.instr = w;
      r.rs1   = $urandom;
      r.rs2   = $urandom;
      reqs.push_back(r);
      expect_addrs(r.rs1, (mop == strided) ? r.rs2 : elem_size(w.mem.width), st);
      d.cls   = st ? (idx ? CLS_STORE_IDX : CLS_STORE) : (idx ? CLS_LOAD_IDX : CLS_LOAD);
      d.instr = w;
      d.rs1   = r.rs1;
      d.rs2   = r.rs2;
      exp_ret.push_back(d);
      // unordered indexed load comes back as a unit-stride load at SEW
      if (!st && mop == idx_unordered)
      begin
         w.mem.mop   = unit_stride;
         w.mem.width = sew_code(sew);
         expect_addrs(r.rs1, 32'd1 << sew, 1'b0);
         d.cls   = CLS_LOAD;
         d.instr = w;
         exp_ret.push_back(d);
      end
   endtask

   task automatic run_test(input string name, input int kind, input int n,
                           input logic [1:0] sew, input int bp);
      int   sent;
      int   quiet;
      int   err0;
      int   pick;
      logic hold;
      err0 = errors;
      reqs.delete();
      for (int i = 0; i < n; i++)
      begin
         pick = $urandom_range(0, 2);
         case (kind)
            0: add_arith(1'b0);
            1: add_mem(v_ld_opcode, $urandom_range(0, 1) ? strided : unit_stride, sew);
            2: add_mem(v_st_opcode, mop_e'($urandom_range(0, 3)), sew);
            3: add_mem(v_ld_opcode, $urandom_range(0, 2) ? idx_unordered : idx_ordered, sew);
            4:
               if (pick == 0)
                  add_arith(1'b0);
               else
                  add_mem((pick == 1) ? v_ld_opcode : v_st_opcode,
                          mop_e'($urandom_range(0, 3)), sew);
            default:
               if (pick == 2)
                  add_mem(v_ld_opcode, $urandom_range(0, 1) ? strided : unit_stride, sew);
               else
                  add_arith(pick == 0);
         endcase
      end
      @(posedge clk);
      sew_i <= sew;
      sent  = 0;
      quiet = 0;
      // keep watching a while after the last record for extras
      while (quiet < 20)
      begin
         @(posedge clk);
         hold = in_valid_i && !in_ready_o;
         if (in_valid_i && in_ready_o)
            sent++;
         if (mem_req_valid_o && mem_req_ready_i)
         begin
            if (exp_addr.size() == 0)
            begin
               errors++;
               $display("unexpected memory request in %s", name);
            end
            else
               compare({name, " address"}, CMP_W'(exp_addr.pop_front()), CMP_W'(mem_req_o));
         end
         if (retire_valid_o && retire_ready_i)
         begin
            if (exp_ret.size() == 0)
            begin
               errors++;
               $display("unexpected retire record in %s", name);
            end
            else
               compare({name, " retire"}, exp_ret.pop_front(), retire_o);
         end
         in_valid_i      <= (sent < n) && (hold || $urandom_range(0, 3) != 0);
         in_data_i       <= (sent < n) ? reqs[sent] : '0;
         mem_req_ready_i <= ($urandom_range(0, 3) >= bp);
         retire_ready_i  <= ($urandom_range(0, 3) >= bp);
         if (sent == n && exp_ret.size() == 0 && exp_addr.size() == 0)
            quiet++;
      end
      $display("%s: %0d instructions, %0d errors", name, n, errors - err0);
   endtask

   initial
   begin
      void'($urandom(74));
      rstn            = 1'b0;
      sew_i           = 2'd0;
      in_valid_i      = 1'b0;
      in_data_i       = '0;
      mem_req_ready_i = 1'b0;
      retire_ready_i  = 1'b0;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      run_test("arith_classes", 0, 24, 2'd0, 1);
      run_test("load_unit_strided", 1, 12, 2'd0, 1);
      run_test("store_all_mop", 2, 12, 2'd1, 1);
      run_test("indexed_load_split", 3, 8, 2'd2, 1);
      run_test("backpressure_mix", 4, 24, 2'd3, 3);
      run_test("cfg_order", 5, 16, 2'd1, 2);
      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* dv/vector_issue_assert.sv */
// handshake, reset and memory ordering assertions on the scheduler
module vector_issue_assert (
   input logic               clk,
   input logic               rstn,
   input logic               disp_valid,
   input logic               disp_ready,
   input vec_pkg::dispatch_t disp,
   input logic               desc_valid,
   input logic               desc_ready,
   input vec_pkg::mem_desc_t desc,
   input logic               mem_done
);
   import vec_pkg::*;

   // payload held until the consumer takes it
   assert property (@(posedge clk) disable iff (!rstn)
      disp_valid && !disp_ready |=> disp_valid && $stable(disp))
      else $error("dispatch dropped or changed before disp_ready");

   assert property (@(posedge clk) disable iff (!rstn)
      desc_valid && !desc_ready |=> desc_valid && $stable(desc))
      else $error("descriptor dropped or changed before desc_ready");

   assert property (@(posedge clk) !rstn |=> !disp_valid && !desc_valid && !mem_done)
      else $error("control output high during reset");

   // memory dispatch only once the address stream is done
   assert property (@(posedge clk) disable iff (!rstn)
      $rose(disp_valid) && (disp.cls inside {CLS_LOAD, CLS_LOAD_IDX, CLS_STORE, CLS_STORE_IDX})
      |-> $past(mem_done))
      else $error("memory class dispatched before mem_done");

endmodule

bind vec_scheduler vector_issue_assert u_sched_assert (
   .clk(clk), .rstn(rstn),
   .disp_valid(disp_valid_o), .disp_ready(disp_ready_i), .disp(disp_o),
   .desc_valid(desc_valid_o), .desc_ready(desc_ready_i), .desc(desc_o),
   .mem_done(mem_done_i)
);

/* hdl/vector_issue_top.sv */
// top of the vector issue stage
// FIFO, scheduler, memory CU and vector CU
module vector_issue_top #(
   parameter int FIFO_DEPTH   = 4,
   parameter int NUM_ELEM     = 8,
   parameter int RETIRE_DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic [1:0]           sew_i,
   input  logic                 in_valid_i,
   output logic                 in_ready_o,
   input  vec_pkg::scalar_req_t in_data_i,
   output logic                 mem_req_valid_o,
   input  logic                 mem_req_ready_i,
   output vec_pkg::mem_req_t    mem_req_o,
   output logic                 retire_valid_o,
   input  logic                 retire_ready_i,
   output vec_pkg::dispatch_t   retire_o
);
   import vec_pkg::*;

   scalar_req_t head;
   logic        head_valid;
   logic        head_ready;
   dispatch_t   disp;
   logic        disp_valid;
   logic        disp_ready;
   mem_desc_t   desc;
   logic        desc_valid;
   logic        desc_ready;
   logic        mem_done;

   instr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rstn(rstn),
      .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_data_i(in_data_i),
      .out_valid_o(head_valid), .out_ready_i(head_ready), .out_data_o(head)
   );

   vec_scheduler u_sched (
      .clk(clk), .rstn(rstn), .sew_i(sew_i),
      .req_valid_i(head_valid), .req_ready_o(head_ready), .req_i(head),
      .disp_valid_o(disp_valid), .disp_ready_i(disp_ready), .disp_o(disp),
      .desc_valid_o(desc_valid), .desc_ready_i(desc_ready), .desc_o(desc),
      .mem_done_i(mem_done)
   );

   mem_agu #(.NUM_ELEM(NUM_ELEM)) u_agu (
      .clk(clk), .rstn(rstn),
      .desc_valid_i(desc_valid), .desc_ready_o(desc_ready), .desc_i(desc),
      .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
      .mem_req_o(mem_req_o), .done_o(mem_done)
   );

   vec_cu #(.RETIRE_DEPTH(RETIRE_DEPTH)) u_cu (
      .clk(clk), .rstn(rstn),
      .disp_valid_i(disp_valid), .disp_ready_o(disp_ready), .disp_i(disp),
      .retire_valid_o(retire_valid_o), .retire_ready_i(retire_ready_i),
      .retire_o(retire_o)
   );

endmodule

/* hdl/vec_cu.sv */
// vector control unit
// in-order retire queue with pending count per issue class
module vec_cu #(
   parameter int RETIRE_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               disp_valid_i,
   output logic               disp_ready_o,
   input  vec_pkg::dispatch_t disp_i,
   output logic               retire_valid_o,
   input  logic               retire_ready_i,
   output vec_pkg::dispatch_t retire_o
);
   import vec_pkg::*;

   localparam int PTR_W = (RETIRE_DEPTH > 1) ? $clog2(RETIRE_DEPTH) : 1;
   localparam int CNT_W = $clog2(RETIRE_DEPTH + 1);

   dispatch_t        rq_q [RETIRE_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] pend_q [NUM_CLS];
   logic             other_pend;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(RETIRE_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // anything but a config change still in flight
   always_comb
   begin
      other_pend = 1'b0;
      for (int i = 0; i < NUM_CLS; i++)
         if (i != int'(CLS_CFG) && pend_q[i] != '0)
            other_pend = 1'b1;
   end

   assign disp_ready_o   = (cnt_q != CNT_W'(RETIRE_DEPTH)) &&
                           !(disp_i.cls == CLS_CFG && other_pend);
   assign push           = disp_valid_i && disp_ready_o;
   assign retire_valid_o = (cnt_q != '0);
   assign pop            = retire_valid_o && retire_ready_i;
   assign retire_o       = rq_q[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
         for (int i = 0; i < NUM_CLS; i++)
            pend_q[i] <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop)
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         if (push && !pop)
            cnt_q <= cnt_q + 1'b1;
         else if (pop && !push)
            cnt_q <= cnt_q - 1'b1;
         for (int i = 0; i < NUM_CLS; i++)
         begin
            if (push && disp_i.cls == issue_class_e'(i) &&
                !(pop && retire_o.cls == issue_class_e'(i)))
               pend_q[i] <= pend_q[i] + 1'b1;
            else if (pop && retire_o.cls == issue_class_e'(i) &&
                     !(push && disp_i.cls == issue_class_e'(i)))
               pend_q[i] <= pend_q[i] - 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         rq_q[wr_ptr_q] <= disp_i;
   end

endmodule

/* hdl/mem_agu.sv */
// memory control unit
// walks one load/store descriptor as NUM_ELEM element addresses
module mem_agu #(
   parameter int NUM_ELEM = 8
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               desc_valid_i,
   output logic               desc_ready_o,
   input  vec_pkg::mem_desc_t desc_i,
   output logic               mem_req_valid_o,
   input  logic               mem_req_ready_i,
   output vec_pkg::mem_req_t  mem_req_o,
   output logic               done_o
);
   import vec_pkg::*;

   localparam int CNT_W = (NUM_ELEM > 1) ? $clog2(NUM_ELEM) : 1;

   logic             busy_q;
   logic             done_q;
   logic             is_store_q;
   logic [CNT_W-1:0] elem_q;
   logic [31:0]      addr_q;
   logic [31:0]      step_q;
   logic             desc_fire;
   logic             req_fire;
   logic             last;

   // bytes per element of a width code
   function automatic logic [31:0] elem_bytes(input logic [2:0] width);
      logic [31:0] b;
      case (width)
         3'd5:    b = 32'd2;
         3'd6:    b = 32'd4;
         3'd7:    b = 32'd8;
         default: b = 32'd1;
      endcase
      return b;
   endfunction

   assign desc_ready_o = !busy_q;
   assign desc_fire    = desc_valid_i && desc_ready_o;
   assign req_fire     = mem_req_valid_o && mem_req_ready_i;
   assign last         = (elem_q == CNT_W'(NUM_ELEM - 1));

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         busy_q <= 1'b0;
         done_q <= 1'b0;
         elem_q <= '0;
      end
      else
      begin
         done_q <= 1'b0;
         if (desc_fire)
         begin
            busy_q <= 1'b1;
            elem_q <= '0;
         end
         else if (req_fire)
         begin
            if (last)
            begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
            else
               elem_q <= elem_q + 1'b1;
         end
      end
   end

   // indexed modes read the index vector unit-stride
   always_ff @(posedge clk)
   begin
      if (desc_fire)
      begin
         addr_q     <= desc_i.base;
         step_q     <= (desc_i.mode == strided) ? desc_i.stride : elem_bytes(desc_i.width);
         is_store_q <= desc_i.is_store;
      end
      else if (req_fire)
         addr_q <= addr_q + step_q;
   end

   assign mem_req_valid_o    = busy_q;
   assign mem_req_o.addr     = addr_q;
   assign mem_req_o.is_store = is_store_q;
   assign done_o             = done_q;

endmodule

/* hdl/vec_scheduler.sv */
// scheduler of the vector issue stage
// decodes the held word, issues memory descriptors, dispatches to the vector CU
module vec_scheduler (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic [1:0]           sew_i,
   input  logic                 req_valid_i,
   output logic                 req_ready_o,
   input  vec_pkg::scalar_req_t req_i,
   output logic                 disp_valid_o,
   input  logic                 disp_ready_i,
   output vec_pkg::dispatch_t   disp_o,
   output logic                 desc_valid_o,
   input  logic                 desc_ready_i,
   output vec_pkg::mem_desc_t   desc_o,
   input  logic                 mem_done_i
);
   import vec_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_DESC,
      S_WAIT,
      S_DISP
   } state_e;

   state_e       state_q;
   scalar_req_t  cur_q;
   issue_class_e cls_q;
   issue_class_e req_cls;
   vec_instr_u   part2;
   logic [2:0]   sew_width;
   logic         req_fire;
   logic         desc_fire;
   logic         disp_fire;
   logic         split;

   function automatic issue_class_e decode_class(input vec_instr_u w);
      issue_class_e c;
      c = CLS_ILLEGAL;
      case (w.arith.opcode)
         v_arith_opcode:
            case (w.arith.funct3)
               OPIVV, OPIVI, OPIVX:
                  c = CLS_INT;
               OPMVV, OPMVX:
                  c = (w.arith.funct6[5:3] == 3'b101) ? CLS_MASK101 : CLS_MASK;
               OPCFG:
                  c = CLS_CFG;
               // no floating-point class in this unit
               OPFVV, OPFVF:
                  c = CLS_ILLEGAL;
               default:
                  c = CLS_ILLEGAL;
            endcase
         v_ld_opcode:
            c = (w.mem.mop inside {idx_unordered, idx_ordered}) ? CLS_LOAD_IDX : CLS_LOAD;
         v_st_opcode:
            c = (w.mem.mop inside {idx_unordered, idx_ordered}) ? CLS_STORE_IDX : CLS_STORE;
         default:
            c = CLS_ILLEGAL;
      endcase
      return c;
   endfunction

   function automatic logic is_mem_class(input issue_class_e c);
      return c inside {CLS_LOAD, CLS_LOAD_IDX, CLS_STORE, CLS_STORE_IDX};
   endfunction

   assign req_cls   = decode_class(req_i.instr);
   assign req_fire  = req_valid_i && req_ready_o;
   assign desc_fire = desc_valid_o && desc_ready_i;
   assign disp_fire = disp_valid_o && disp_ready_i;

   // width code of the current SEW, 8/16/32/64 bit
   assign sew_width = (sew_i == 2'd0) ? 3'b000 : {1'b1, sew_i};

   // second half of an unordered indexed load
   always_comb
   begin
      part2           = cur_q.instr;
      part2.mem.mop   = unit_stride;
      part2.mem.width = sew_width;
   end

   assign split = (cls_q == CLS_LOAD_IDX) && (cur_q.instr.mem.mop == idx_unordered);

   always_ff @(posedge clk)
   begin
      if (!rstn)
         state_q <= S_IDLE;
      else
      begin
         case (state_q)
            S_IDLE:
               if (req_fire)
                  state_q <= is_mem_class(req_cls) ? S_DESC : S_DISP;
            S_DESC:
               if (desc_fire)
                  state_q <= S_WAIT;
            S_WAIT:
               if (mem_done_i)
                  state_q <= S_DISP;
            S_DISP:
               // part 2 is always a load and goes back to the descriptor step
               if (disp_fire)
                  state_q <= split ? S_DESC : S_IDLE;
            default:
               state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (req_fire)
      begin
         cur_q <= req_i;
         cls_q <= req_cls;
      end
      else if (disp_fire && split)
      begin
         cur_q.instr <= part2;
         cls_q       <= decode_class(part2);
      end
   end

   assign req_ready_o  = (state_q == S_IDLE);
   assign desc_valid_o = (state_q == S_DESC);
   assign disp_valid_o = (state_q == S_DISP);

   assign desc_o.base     = cur_q.rs1;
   assign desc_o.stride   = cur_q.rs2;
   assign desc_o.width    = cur_q.instr.mem.width;
   assign desc_o.mode     = cur_q.instr.mem.mop;
   assign desc_o.is_store = (cur_q.instr.mem.opcode == v_st_opcode);

   assign disp_o.cls   = cls_q;
   assign disp_o.instr = cur_q.instr;
   assign disp_o.rs1   = cur_q.rs1;
   assign disp_o.rs2   = cur_q.rs2;

endmodule

/* hdl/instr_fifo.sv */
// instruction FIFO between the scalar core and the scheduler
module instr_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 in_valid_i,
   output logic                 in_ready_o,
   input  vec_pkg::scalar_req_t in_data_i,
   output logic                 out_valid_o,
   input  logic                 out_ready_i,
   output vec_pkg::scalar_req_t out_data_o
);
   import vec_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   scalar_req_t      mem_q [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             run_q;
   logic             push;
   logic             pop;
   logic             full;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full        = (cnt_q == CNT_W'(FIFO_DEPTH));
   assign out_valid_o = (cnt_q != '0);
   assign out_data_o  = mem_q[rd_ptr_q];
   // full but draining still frees a slot this cycle
   assign in_ready_o  = run_q && (!full || out_ready_i);
   assign push        = in_valid_i && in_ready_o;
   assign pop         = out_valid_o && out_ready_i;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
         run_q    <= 1'b0;
      end
      else
      begin
         run_q <= 1'b1;
         if (push)
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop)
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         if (push && !pop)
            cnt_q <= cnt_q + 1'b1;
         else if (pop && !push)
            cnt_q <= cnt_q - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem_q[wr_ptr_q] <= in_data_i;
   end

endmodule

/* hdl/vec_pkg.sv */
// shared encodings and issue classes of the vector issue stage
// instruction union and the structs passed between blocks
package vec_pkg;

   // major opcodes
   localparam logic [6:0] v_ld_opcode    = 7'b0000111;
   localparam logic [6:0] v_st_opcode    = 7'b0100111;
   localparam logic [6:0] v_arith_opcode = 7'b1010111;

   // funct3 category of an arithmetic word
   localparam logic [2:0] OPIVV = 3'b000;
   localparam logic [2:0] OPFVV = 3'b001;
   localparam logic [2:0] OPMVV = 3'b010;
   localparam logic [2:0] OPIVI = 3'b011;
   localparam logic [2:0] OPIVX = 3'b100;
   localparam logic [2:0] OPFVF = 3'b101;
   localparam logic [2:0] OPMVX = 3'b110;
   localparam logic [2:0] OPCFG = 3'b111;

   typedef enum logic [1:0] {
      unit_stride   = 2'b00,
      idx_unordered = 2'b01,
      strided       = 2'b10,
      idx_ordered   = 2'b11
   } mop_e;

   // nine classes need a fourth bit
   typedef enum logic [3:0] {
      CLS_INT       = 4'd0,
      CLS_MASK      = 4'd1,
      CLS_MASK101   = 4'd2,
      CLS_CFG       = 4'd3,
      CLS_LOAD      = 4'd4,
      CLS_LOAD_IDX  = 4'd5,
      CLS_STORE     = 4'd6,
      CLS_STORE_IDX = 4'd7,
      CLS_ILLEGAL   = 4'd8
   } issue_class_e;

   localparam int NUM_CLS = 9;

   typedef struct packed {
      logic [5:0] funct6;
      logic       vm;
      logic [4:0] vs2;
      logic [4:0] vs1;
      logic [2:0] funct3;
      logic [4:0] vd;
      logic [6:0] opcode;
   } arith_fmt_t;

   typedef struct packed {
      logic [2:0] nf;
      logic       mew;
      mop_e       mop;
      logic       vm;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] width;
      logic [4:0] vd;
      logic [6:0] opcode;
   } mem_fmt_t;

   // one word, read either as arithmetic or as load/store format
   typedef union packed {
      arith_fmt_t arith;
      mem_fmt_t   mem;
   } vec_instr_u;

   typedef struct packed {
      vec_instr_u  instr;
      logic [31:0] rs1;
      logic [31:0] rs2;
   } scalar_req_t;

   typedef struct packed {
      issue_class_e cls;
      logic [31:0]  instr;
      logic [31:0]  rs1;
      logic [31:0]  rs2;
   } dispatch_t;

   typedef struct packed {
      logic [31:0] base;
      logic [31:0] stride;
      logic [2:0]  width;
      mop_e        mode;
      logic        is_store;
   } mem_desc_t;

   typedef struct packed {
      logic [31:0] addr;
      logic        is_store;
   } mem_req_t;

endpackage
